// File: Makefile
# Verilator flow for the CSR file testbench
TOP       ?= csr_file_tb
SEED      ?= 72
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/10ps

SOURCES := build.f $(wildcard design/*.sv design/*.svh dv/*.sv)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f build.f --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f build.f --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the log holds the pass line
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+design
design/csr_pkg.sv
design/csr_counters.sv
design/csr_irq_regs.sv
design/csr_trap_regs.sv
design/csr_read_mux.sv
design/csr_file.sv
dv/csr_file_assert.sv
dv/csr_file_checker.sv
dv/csr_file_tb.sv

// File: design/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// data and address widths
`define CSR_XLEN   32
`define CSR_ADDR_W 12

// machine information registers, read-only
`define CSR_ADDR_MVENDORID 12'hF11
`define CSR_ADDR_MARCHID   12'hF12
`define CSR_ADDR_MIMPID    12'hF13
`define CSR_ADDR_MHARTID   12'hF14

// machine trap setup and handling
`define CSR_ADDR_MSTATUS  12'h300
`define CSR_ADDR_MISA     12'h301
`define CSR_ADDR_MIE      12'h304
`define CSR_ADDR_MTVEC    12'h305
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MEPC     12'h341
`define CSR_ADDR_MCAUSE   12'h342
`define CSR_ADDR_MTVAL    12'h343
`define CSR_ADDR_MIP      12'h344

// machine counters and their user-level aliases
`define CSR_ADDR_MCYCLE    12'hB00
`define CSR_ADDR_MINSTRET  12'hB02
`define CSR_ADDR_MCYCLEH   12'hB80
`define CSR_ADDR_MINSTRETH 12'hB82
`define CSR_ADDR_CYCLE     12'hC00
`define CSR_ADDR_CYCLEH    12'hC80

// mxl = 1 (rv32), extensions i (bit 8) and m (bit 12)
`define CSR_MISA_VALUE  32'h4000_1100
`define CSR_MTVEC_RESET 32'h0000_0100

// bit positions inside mstatus
`define CSR_MSTATUS_MIE_BIT  3
`define CSR_MSTATUS_MPIE_BIT 7

// bit positions shared by mie and mip
`define CSR_IRQ_SW_BIT    3
`define CSR_IRQ_TIMER_BIT 7
`define CSR_IRQ_EXT_BIT   11

`endif

// File: design/csr_counters.sv
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_counters (
    input  logic               clk_i,
    input  logic               n_rst_i,
    input  logic               instret_incr_i,
    output csr_pkg::counters_t counters_o
);

    csr_pkg::counters_t cnt_q;

    // mcycle runs freely, minstret counts retire pulses
    // both wrap through zero at 2^64
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            cnt_q.mcycle   <= '0;
            cnt_q.minstret <= '0;
        end else begin
            cnt_q.mcycle <= cnt_q.mcycle + 64'd1;
            if (instret_incr_i) begin
                cnt_q.minstret <= cnt_q.minstret + 64'd1;
            end
        end
    end

    assign counters_o = cnt_q;

endmodule

// File: design/csr_file.sv
`timescale 1ns/10ps

module csr_file (
    input  logic                  clk_i,
    input  logic                  n_rst_i,
    input  csr_pkg::irq_bits_t    irq_i,
    input  csr_pkg::csr_write_t   csr_wr_i,
    input  csr_pkg::csr_addr_t    raddr_i,
    output csr_pkg::csr_data_t    rdata_o,
    input  logic                  instret_incr_i,
    input  csr_pkg::trap_update_t trap_i,
    output logic                  mstatus_ie_o,
    output csr_pkg::irq_bits_t    mie_o,
    output csr_pkg::irq_bits_t    mip_o,
    output csr_pkg::csr_data_t    mtvec_o,
    output csr_pkg::csr_data_t    epc_o
);

    csr_pkg::counters_t   counters;
    csr_pkg::trap_state_t trap_state;

    // mcycle and minstret
    csr_counters u_counters (
        .clk_i          (clk_i),
        .n_rst_i        (n_rst_i),
        .instret_incr_i (instret_incr_i),
        .counters_o     (counters)
    );

    // interrupt enable and pending bits
    csr_irq_regs u_irq_regs (
        .clk_i    (clk_i),
        .n_rst_i  (n_rst_i),
        .irq_i    (irq_i),
        .csr_wr_i (csr_wr_i),
        .mie_o    (mie_o),
        .mip_o    (mip_o)
    );

    // mstatus and the trap handling registers
    csr_trap_regs u_trap_regs (
        .clk_i    (clk_i),
        .n_rst_i  (n_rst_i),
        .csr_wr_i (csr_wr_i),
        .trap_i   (trap_i),
        .state_o  (trap_state)
    );

    csr_read_mux u_read_mux (
        .raddr_i    (raddr_i),
        .csr_wr_i   (csr_wr_i),
        .counters_i (counters),
        .trap_i     (trap_state),
        .mie_i      (mie_o),
        .mip_i      (mip_o),
        .rdata_o    (rdata_o)
    );

    // controller-facing copies of the trap state
    assign mstatus_ie_o = trap_state.mstatus_ie;
    assign mtvec_o      = trap_state.mtvec;
    assign epc_o        = trap_state.mepc;

endmodule

// File: design/csr_irq_regs.sv
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_irq_regs (
    input  logic                clk_i,
    input  logic                n_rst_i,
    input  csr_pkg::irq_bits_t  irq_i,
    input  csr_pkg::csr_write_t csr_wr_i,
    output csr_pkg::irq_bits_t  mie_o,
    output csr_pkg::irq_bits_t  mip_o
);

    csr_pkg::irq_bits_t mie_q;
    csr_pkg::irq_bits_t mip_q;
    logic               wr_mie;

    // only mie is writable, a write to mip address falls through here
    assign wr_mie = csr_wr_i.en && (csr_wr_i.addr == `CSR_ADDR_MIE);

    // pending bits are a plain one-cycle sample of the interrupt lines
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            mip_q <= '0;
        end else begin
            mip_q <= irq_i;
        end
    end

    // enable bits picked from their architectural positions
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            mie_q <= '0;
        end else if (wr_mie) begin
            mie_q.ext   <= csr_wr_i.data[`CSR_IRQ_EXT_BIT];
            mie_q.timer <= csr_wr_i.data[`CSR_IRQ_TIMER_BIT];
            mie_q.sw    <= csr_wr_i.data[`CSR_IRQ_SW_BIT];
        end
    end

    assign mie_o = mie_q;
    assign mip_o = mip_q;

endmodule

// File: design/csr_pkg.sv
`include "csr_config.svh"

package csr_pkg;

    // csr number as seen on the read and write ports
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    // one register word
    typedef logic [`CSR_XLEN-1:0] csr_data_t;
    // full width of mcycle and minstret
    typedef logic [2*`CSR_XLEN-1:0] csr_count_t;
    // exception or interrupt code loaded into mcause
    typedef logic [3:0] cause_code_t;

    // software write request from writeback, one cycle strobe
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_data_t data;
    } csr_write_t;

    // updates requested by the trap controller
    typedef struct packed {
        logic        set_cause;
        logic        cause_is_irq;
        cause_code_t cause_code;
        logic        set_epc;
        csr_data_t   epc;
        logic        set_mtval;
        csr_data_t   mtval;
        // trap entry
        logic        ie_clear;
        // trap return
        logic        ie_set;
    } trap_update_t;

    // machine-level software, timer and external interrupt lines
    typedef struct packed {
        logic ext;
        logic timer;
        logic sw;
    } irq_bits_t;

    typedef struct packed {
        csr_count_t mcycle;
        csr_count_t minstret;
    } counters_t;

    // everything held by the trap register group
    typedef struct packed {
        logic      mstatus_ie;
        logic      mstatus_pie;
        csr_data_t mtvec;
        csr_data_t mscratch;
        csr_data_t mepc;
        csr_data_t mcause;
        csr_data_t mtval;
    } trap_state_t;

endpackage

// File: design/csr_read_mux.sv
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_read_mux (
    input  csr_pkg::csr_addr_t   raddr_i,
    input  csr_pkg::csr_write_t  csr_wr_i,
    input  csr_pkg::counters_t   counters_i,
    input  csr_pkg::trap_state_t trap_i,
    input  csr_pkg::irq_bits_t   mie_i,
    input  csr_pkg::irq_bits_t   mip_i,
    output csr_pkg::csr_data_t   rdata_o
);

    // spread the three interrupt bits to their mie/mip positions
    function automatic csr_pkg::csr_data_t pack_irq(input csr_pkg::irq_bits_t bits);
        csr_pkg::csr_data_t word;
        word                     = '0;
        word[`CSR_IRQ_EXT_BIT]   = bits.ext;
        word[`CSR_IRQ_TIMER_BIT] = bits.timer;
        word[`CSR_IRQ_SW_BIT]    = bits.sw;
        return word;
    endfunction

    csr_pkg::csr_data_t mstatus_word;

    // mpp is hardwired to machine mode
    always_comb begin
        mstatus_word                        = '0;
        mstatus_word[12:11]                 = 2'b11;
        mstatus_word[`CSR_MSTATUS_MPIE_BIT] = trap_i.mstatus_pie;
        mstatus_word[`CSR_MSTATUS_MIE_BIT]  = trap_i.mstatus_ie;
    end

    always_comb begin
        if (csr_wr_i.en && (csr_wr_i.addr == raddr_i)) begin
            // same-cycle write wins over the stored value
            rdata_o = csr_wr_i.data;
        end else begin
            case (raddr_i)
                // identity registers are not implemented
                `CSR_ADDR_MVENDORID,
                `CSR_ADDR_MARCHID,
                `CSR_ADDR_MIMPID,
                `CSR_ADDR_MHARTID:   rdata_o = '0;
                `CSR_ADDR_MISA:      rdata_o = `CSR_MISA_VALUE;
                `CSR_ADDR_MSTATUS:   rdata_o = mstatus_word;
                `CSR_ADDR_MIE:       rdata_o = pack_irq(mie_i);
                `CSR_ADDR_MIP:       rdata_o = pack_irq(mip_i);
                `CSR_ADDR_MTVEC:     rdata_o = trap_i.mtvec;
                `CSR_ADDR_MSCRATCH:  rdata_o = trap_i.mscratch;
                `CSR_ADDR_MEPC:      rdata_o = trap_i.mepc;
                `CSR_ADDR_MCAUSE:    rdata_o = trap_i.mcause;
                `CSR_ADDR_MTVAL:     rdata_o = trap_i.mtval;
                // user cycle aliases read the machine counter
                `CSR_ADDR_MCYCLE,
                `CSR_ADDR_CYCLE:     rdata_o = counters_i.mcycle[`CSR_XLEN-1:0];
                `CSR_ADDR_MCYCLEH,
                `CSR_ADDR_CYCLEH:    rdata_o = counters_i.mcycle[2*`CSR_XLEN-1:`CSR_XLEN];
                `CSR_ADDR_MINSTRET:  rdata_o = counters_i.minstret[`CSR_XLEN-1:0];
                `CSR_ADDR_MINSTRETH: rdata_o = counters_i.minstret[2*`CSR_XLEN-1:`CSR_XLEN];
                default:             rdata_o = '0;
            endcase
        end
    end

endmodule

// File: design/csr_trap_regs.sv
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_trap_regs (
    input  logic                  clk_i,
    input  logic                  n_rst_i,
    input  csr_pkg::csr_write_t   csr_wr_i,
    input  csr_pkg::trap_update_t trap_i,
    output csr_pkg::trap_state_t  state_o
);

    csr_pkg::trap_state_t st_q;

    // software write decode, one strobe per register
    logic wr_mstatus;
    logic wr_mtvec;
    logic wr_mscratch;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mtval;

    assign wr_mstatus  = csr_wr_i.en && (csr_wr_i.addr == `CSR_ADDR_MSTATUS);
    assign wr_mtvec    = csr_wr_i.en && (csr_wr_i.addr == `CSR_ADDR_MTVEC);
    assign wr_mscratch = csr_wr_i.en && (csr_wr_i.addr == `CSR_ADDR_MSCRATCH);
    assign wr_mepc     = csr_wr_i.en && (csr_wr_i.addr == `CSR_ADDR_MEPC);
    assign wr_mcause   = csr_wr_i.en && (csr_wr_i.addr == `CSR_ADDR_MCAUSE);
    assign wr_mtval    = csr_wr_i.en && (csr_wr_i.addr == `CSR_ADDR_MTVAL);

    // mstatus ie/pie
    // software write first, then trap entry, then trap return
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            st_q.mstatus_ie  <= 1'b0;
            st_q.mstatus_pie <= 1'b1;
        end else if (wr_mstatus) begin
            st_q.mstatus_ie  <= csr_wr_i.data[`CSR_MSTATUS_MIE_BIT];
            st_q.mstatus_pie <= csr_wr_i.data[`CSR_MSTATUS_MPIE_BIT];
        end else if (trap_i.ie_clear) begin
            // entry saves the enable and masks further interrupts
            st_q.mstatus_pie <= st_q.mstatus_ie;
            st_q.mstatus_ie  <= 1'b0;
        end else if (trap_i.ie_set) begin
            // mret restores the saved enable
            st_q.mstatus_ie  <= st_q.mstatus_pie;
            st_q.mstatus_pie <= 1'b1;
        end
    end

    // trap vector base and mode, written only by software
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            st_q.mtvec <= `CSR_MTVEC_RESET;
        end else if (wr_mtvec) begin
            st_q.mtvec <= csr_wr_i.data;
        end
    end

    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            st_q.mscratch <= '0;
        end else if (wr_mscratch) begin
            st_q.mscratch <= csr_wr_i.data;
        end
    end

    // ialign is 32, so mepc never holds the two low bits
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            st_q.mepc <= '0;
        end else if (trap_i.set_epc) begin
            st_q.mepc <= {trap_i.epc[`CSR_XLEN-1:2], 2'b00};
        end else if (wr_mepc) begin
            st_q.mepc <= {csr_wr_i.data[`CSR_XLEN-1:2], 2'b00};
        end
    end

    // trap loads interrupt flag in bit 31 and the code in 3:0
    // software may write the full word
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            st_q.mcause <= '0;
        end else if (trap_i.set_cause) begin
            st_q.mcause <= {trap_i.cause_is_irq, {(`CSR_XLEN-5){1'b0}}, trap_i.cause_code};
        end else if (wr_mcause) begin
            st_q.mcause <= csr_wr_i.data;
        end
    end

    // faulting address or instruction bits from the controller
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            st_q.mtval <= '0;
        end else if (trap_i.set_mtval) begin
            st_q.mtval <= trap_i.mtval;
        end else if (wr_mtval) begin
            st_q.mtval <= csr_wr_i.data;
        end
    end

    assign state_o = st_q;

endmodule

// File: dv/csr_file_assert.sv
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_file_assert (
    input logic                  clk_i,
    input logic                  n_rst_i,
    input csr_pkg::irq_bits_t    irq_i,
    input csr_pkg::csr_write_t   csr_wr_i,
    input csr_pkg::trap_update_t trap_i,
    input logic                  mstatus_ie_i,
    input csr_pkg::irq_bits_t    mip_i,
    input csr_pkg::csr_data_t    epc_i
);

    logic wr_mstatus;

    assign wr_mstatus = csr_wr_i.en && (csr_wr_i.addr == `CSR_ADDR_MSTATUS);

    // mepc is word aligned
    a_epc_aligned: assert property (@(posedge clk_i) disable iff (!n_rst_i)
        epc_i[1:0] == 2'b00)
        else $error("epc_o has nonzero low bits");

    // mip is a one cycle sample of the lines
    a_mip_delay: assert property (@(posedge clk_i) disable iff (!n_rst_i)
        mip_i == $past(irq_i))
        else $error("mip_o does not follow irq_i of the previous cycle");

    // trap entry masks interrupts on the next edge
    a_ie_clear: assert property (@(posedge clk_i) disable iff (!n_rst_i)
        trap_i.ie_clear && !wr_mstatus |=> !mstatus_ie_i)
        else $error("mstatus_ie_o still set after ie_clear");

endmodule

bind csr_file csr_file_assert u_assert (
    .clk_i        (clk_i),
    .n_rst_i      (n_rst_i),
    .irq_i        (irq_i),
    .csr_wr_i     (csr_wr_i),
    .trap_i       (trap_i),
    .mstatus_ie_i (mstatus_ie_o),
    .mip_i        (mip_o),
    .epc_i        (epc_o)
);

// File: dv/csr_file_checker.sv
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_file_checker (
    input  logic                  clk_i,
    input  logic                  n_rst_i,
    input  csr_pkg::irq_bits_t    irq_i,
    input  csr_pkg::csr_write_t   csr_wr_i,
    input  csr_pkg::csr_addr_t    raddr_i,
    input  logic                  instret_incr_i,
    input  csr_pkg::trap_update_t trap_i,
    input  csr_pkg::csr_data_t    rdata_i,
    input  logic                  mstatus_ie_i,
    input  csr_pkg::irq_bits_t    mie_i,
    input  csr_pkg::irq_bits_t    mip_i,
    input  csr_pkg::csr_data_t    mtvec_i,
    input  csr_pkg::csr_data_t    epc_i,
    input  int                    test_id_i,
    input  logic                  test_end_i,
    output int                    pass_cnt_o,
    output int                    fail_cnt_o
);

    // reference state
    csr_pkg::csr_count_t m_cycle;
    csr_pkg::csr_count_t m_instret;
    logic                m_ie;
    logic                m_pie;
    csr_pkg::csr_data_t  m_mtvec;
    csr_pkg::csr_data_t  m_mscratch;
    csr_pkg::csr_data_t  m_mepc;
    csr_pkg::csr_data_t  m_mcause;
    csr_pkg::csr_data_t  m_mtval;
    csr_pkg::irq_bits_t  m_mie;
    csr_pkg::irq_bits_t  m_mip;

    int n_pass = 0;
    int n_fail = 0;
    int t_pass = 0;
    int t_fail = 0;

    assign pass_cnt_o = n_pass;
    assign fail_cnt_o = n_fail;

    function automatic string test_name(input int id);
        case (id)
            0:       return "rw_regs";
            1:       return "readonly_unmapped";
            2:       return "write_bypass";
            3:       return "trap_update";
            4:       return "counters";
            5:       return "irq_regs";
            default: return "unknown";
        endcase
    endfunction

    function automatic logic wr_hit(input csr_pkg::csr_addr_t a);
        return csr_wr_i.en && (csr_wr_i.addr == a);
    endfunction

    // ext/timer/sw land on bits 11/7/3
    function automatic csr_pkg::csr_data_t spread(input csr_pkg::irq_bits_t b);
        return (32'(b.ext) << `CSR_IRQ_EXT_BIT) | (32'(b.timer) << `CSR_IRQ_TIMER_BIT)
            | (32'(b.sw) << `CSR_IRQ_SW_BIT);
    endfunction

    function automatic csr_pkg::csr_data_t expect_read(input csr_pkg::csr_addr_t a);
        if (wr_hit(a)) begin
            return csr_wr_i.data;
        end
        case (a)
            `CSR_ADDR_MISA:      return `CSR_MISA_VALUE;
            // mpp reads as machine mode
            `CSR_ADDR_MSTATUS:   return (32'd3 << 11) | (32'(m_pie) << 7) | (32'(m_ie) << 3);
            `CSR_ADDR_MIE:       return spread(m_mie);
            `CSR_ADDR_MIP:       return spread(m_mip);
            `CSR_ADDR_MTVEC:     return m_mtvec;
            `CSR_ADDR_MSCRATCH:  return m_mscratch;
            `CSR_ADDR_MEPC:      return m_mepc;
            `CSR_ADDR_MCAUSE:    return m_mcause;
            `CSR_ADDR_MTVAL:     return m_mtval;
            `CSR_ADDR_MCYCLE,
            `CSR_ADDR_CYCLE:     return m_cycle[31:0];
            `CSR_ADDR_MCYCLEH,
            `CSR_ADDR_CYCLEH:    return m_cycle[63:32];
            `CSR_ADDR_MINSTRET:  return m_instret[31:0];
            `CSR_ADDR_MINSTRETH: return m_instret[63:32];
            // identity registers and holes in the map
            default:             return '0;
        endcase
    endfunction

    task automatic compare_word(input string what, input csr_pkg::csr_data_t exp,
                                input csr_pkg::csr_data_t act);
        if (exp === act) begin
            n_pass++;
            t_pass++;
        end else begin
            n_fail++;
            t_fail++;
            $display("mismatch test=%s %s expected %08h actual %08h",
                     test_name(test_id_i), what, exp, act);
        end
    endtask

    // model advances on the same edge as the dut
    always @(posedge clk_i) begin
        if (!n_rst_i) begin
            m_cycle    = '0;
            m_instret  = '0;
            m_ie       = 1'b0;
            m_pie      = 1'b1;
            m_mtvec    = `CSR_MTVEC_RESET;
            m_mscratch = '0;
            m_mepc     = '0;
            m_mcause   = '0;
            m_mtval    = '0;
            m_mie      = '0;
            m_mip      = '0;
        end else begin
            m_cycle = m_cycle + 64'd1;
            if (instret_incr_i) begin
                m_instret = m_instret + 64'd1;
            end
            m_mip = irq_i;
            if (wr_hit(`CSR_ADDR_MIE)) begin
                m_mie.ext   = csr_wr_i.data[`CSR_IRQ_EXT_BIT];
                m_mie.timer = csr_wr_i.data[`CSR_IRQ_TIMER_BIT];
                m_mie.sw    = csr_wr_i.data[`CSR_IRQ_SW_BIT];
            end
            // software write, then trap entry, then return
            if (wr_hit(`CSR_ADDR_MSTATUS)) begin
                m_ie  = csr_wr_i.data[`CSR_MSTATUS_MIE_BIT];
                m_pie = csr_wr_i.data[`CSR_MSTATUS_MPIE_BIT];
            end else if (trap_i.ie_clear) begin
                m_pie = m_ie;
                m_ie  = 1'b0;
            end else if (trap_i.ie_set) begin
                m_ie  = m_pie;
                m_pie = 1'b1;
            end
            if (wr_hit(`CSR_ADDR_MTVEC)) m_mtvec = csr_wr_i.data;
            if (wr_hit(`CSR_ADDR_MSCRATCH)) m_mscratch = csr_wr_i.data;
            // trap strobes win over software in these three
            if (trap_i.set_epc) begin
                m_mepc = trap_i.epc & ~32'h3;
            end else if (wr_hit(`CSR_ADDR_MEPC)) begin
                m_mepc = csr_wr_i.data & ~32'h3;
            end
            if (trap_i.set_cause) begin
                m_mcause = (32'(trap_i.cause_is_irq) << 31) | 32'(trap_i.cause_code);
            end else if (wr_hit(`CSR_ADDR_MCAUSE)) begin
                m_mcause = csr_wr_i.data;
            end
            if (trap_i.set_mtval) begin
                m_mtval = trap_i.mtval;
            end else if (wr_hit(`CSR_ADDR_MTVAL)) begin
                m_mtval = csr_wr_i.data;
            end
        end
    end

    // compare mid-cycle when inputs and combinational outputs are settled
    always @(negedge clk_i) begin
        if (n_rst_i) begin
            compare_word($sformatf("rdata_o @%03h", raddr_i), expect_read(raddr_i), rdata_i);
            compare_word("mstatus_ie_o", 32'(m_ie), 32'(mstatus_ie_i));
            compare_word("mie_o", {29'd0, m_mie}, {29'd0, mie_i});
            compare_word("mip_o", {29'd0, m_mip}, {29'd0, mip_i});
            compare_word("mtvec_o", m_mtvec, mtvec_i);
            compare_word("epc_o", m_mepc, epc_i);
        end
        if (test_end_i) begin
            if (t_pass + t_fail == 0) begin
                n_fail++;
                $display("test %s: no checks were made", test_name(test_id_i));
            end else begin
                $display("test %s: %0d checks, %0d errors",
                         test_name(test_id_i), t_pass + t_fail, t_fail);
            end
            t_pass = 0;
            t_fail = 0;
        end
    end

endmodule

// File: dv/csr_file_tb.sv
`timescale 1ns/10ps
`include "csr_config.svh"

module csr_file_tb;

    localparam int PHASES      = 6;
    localparam int PHASE_LEN   = 200;
    localparam int CYCLE_LIMIT = PHASES * PHASE_LEN + 100;

    // address window per phase into the table of map_addr
    localparam int unsigned PH_LO [6] = '{1, 8, 0, 0, 13, 6};
    localparam int unsigned PH_N  [6] = '{6, 5, 19, 4, 6, 2};

    logic                  clk_i;
    logic                  n_rst_i;
    csr_pkg::irq_bits_t    irq;
    csr_pkg::csr_write_t   csr_wr;
    csr_pkg::csr_addr_t    raddr;
    csr_pkg::csr_data_t    rdata;
    logic                  instret_incr;
    csr_pkg::trap_update_t trap;
    logic                  mstatus_ie;
    csr_pkg::irq_bits_t    mie;
    csr_pkg::irq_bits_t    mip;
    csr_pkg::csr_data_t    mtvec;
    csr_pkg::csr_data_t    epc;
    int                    test_id;
    logic                  test_end;
    int                    pass_cnt;
    int                    fail_cnt;
    int                    cycle_cnt = 0;

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    csr_file uut (
        .clk_i          (clk_i),
        .n_rst_i        (n_rst_i),
        .irq_i          (irq),
        .csr_wr_i       (csr_wr),
        .raddr_i        (raddr),
        .rdata_o        (rdata),
        .instret_incr_i (instret_incr),
        .trap_i         (trap),
        .mstatus_ie_o   (mstatus_ie),
        .mie_o          (mie),
        .mip_o          (mip),
        .mtvec_o        (mtvec),
        .epc_o          (epc)
    );

    csr_file_checker u_checker (
        .clk_i          (clk_i),
        .n_rst_i        (n_rst_i),
        .irq_i          (irq),
        .csr_wr_i       (csr_wr),
        .raddr_i        (raddr),
        .instret_incr_i (instret_incr),
        .trap_i         (trap),
        .rdata_i        (rdata),
        .mstatus_ie_i   (mstatus_ie),
        .mie_i          (mie),
        .mip_i          (mip),
        .mtvec_i        (mtvec),
        .epc_i          (epc),
        .test_id_i      (test_id),
        .test_end_i     (test_end),
        .pass_cnt_o     (pass_cnt),
        .fail_cnt_o     (fail_cnt)
    );

    // table order groups the addresses each phase aims at
    function automatic csr_pkg::csr_addr_t map_addr(input int unsigned k);
        case (k)
            0:       return `CSR_ADDR_MSTATUS;
            1:       return `CSR_ADDR_MEPC;
            2:       return `CSR_ADDR_MCAUSE;
            3:       return `CSR_ADDR_MTVAL;
            4:       return `CSR_ADDR_MTVEC;
            5:       return `CSR_ADDR_MSCRATCH;
            6:       return `CSR_ADDR_MIE;
            7:       return `CSR_ADDR_MIP;
            8:       return `CSR_ADDR_MVENDORID;
            9:       return `CSR_ADDR_MARCHID;
            10:      return `CSR_ADDR_MIMPID;
            11:      return `CSR_ADDR_MHARTID;
            12:      return `CSR_ADDR_MISA;
            13:      return `CSR_ADDR_MCYCLE;
            14:      return `CSR_ADDR_MCYCLEH;
            15:      return `CSR_ADDR_MINSTRET;
            16:      return `CSR_ADDR_MINSTRETH;
            17:      return `CSR_ADDR_CYCLE;
            default: return `CSR_ADDR_CYCLEH;
        endcase
    endfunction

    function automatic csr_pkg::csr_addr_t pick_addr(input int phase);
        int unsigned r;
        r = $urandom;
        // 0x7c0..0x7ff holds no implemented csr
        if ((phase == 1 || phase == 2) && r[1:0] == 2'b00) begin
            return {6'h1F, r[7:2]};
        end
        return map_addr(PH_LO[phase] + (r >> 8) % PH_N[phase]);
    endfunction

    // one cycle of random stimulus, phase picks the address window
    task automatic drive_cycle(input int phase);
        csr_pkg::csr_write_t   wr;
        csr_pkg::trap_update_t tu;
        csr_pkg::csr_addr_t    ra;
        logic [31:0]           rnd;
        logic [31:0]           ctl;
        rnd     = $urandom;
        ctl     = $urandom;
        wr.en   = ctl[0] | (phase == 2);
        wr.addr = pick_addr(phase);
        wr.data = $urandom;
        ra      = pick_addr(phase);
        // phase 2 always reads the address under write
        if (phase == 2 || ctl[7:5] == 3'b000) begin
            ra = wr.addr;
        end
        tu = '0;
        if (phase == 3) begin
            tu.set_cause    = rnd[0] & rnd[1];
            tu.cause_is_irq = rnd[2];
            tu.cause_code   = rnd[6:3];
            tu.set_epc      = rnd[7] & rnd[8];
            tu.epc          = $urandom;
            tu.set_mtval    = rnd[9] & rnd[10];
            tu.mtval        = $urandom;
            tu.ie_clear     = rnd[11] & rnd[12];
            tu.ie_set       = rnd[13] & rnd[14];
        end
        @(posedge clk_i);
        csr_wr       <= wr;
        raddr        <= ra;
        trap         <= tu;
        irq          <= ctl[3:1];
        instret_incr <= ctl[4];
        test_end     <= 1'b0;
    endtask

    initial begin
        void'($urandom(72));
        n_rst_i      = 1'b0;
        irq          = '0;
        csr_wr       = '0;
        // first read after reset looks at misa
        raddr        = `CSR_ADDR_MISA;
        instret_incr = 1'b0;
        trap         = '0;
        test_id      = 0;
        test_end     = 1'b0;
        repeat (2) @(posedge clk_i);
        n_rst_i <= 1'b1;
        for (int p = 0; p < PHASES; p++) begin
            test_id <= p;
            repeat (PHASE_LEN) drive_cycle(p);
            // quiet cycle that closes the test
            @(posedge clk_i);
            csr_wr   <= '0;
            trap     <= '0;
            test_end <= 1'b1;
            @(posedge clk_i);
            test_end <= 1'b0;
        end
        repeat (2) @(posedge clk_i);
        $display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk_i);
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
